// ==== hdl/mesh_cache_config.svh ====
/*
  Sizes and widths of the mesh cache test subsystem.
  MC_SETS, MC_WAYS and MC_FIFO_ELS must be powers of two, MC_WAYS at least 2.
*/
`ifndef MESH_CACHE_CONFIG_SVH
`define MESH_CACHE_CONFIG_SVH

`define MC_ADDR_W       12    // word address.
`define MC_DATA_W       32
`define MC_X_W          4
`define MC_Y_W          4

`define MC_SETS         8
`define MC_WAYS         2
`define MC_MEM_SIZE     64    // words exercised, more than the cache holds.

`define MC_MAX_CREDITS  8
`define MC_FIFO_ELS     4
`define MC_MEM_LAT      3     // read latency of the backing memory.

`endif

// ==== hdl/mesh_pkt_pkg.sv ====
/*
  Packet types on the master, endpoint and cache links.
  No byte mask: every access is a full word.
*/
`include "mesh_cache_config.svh"

package mesh_pkt_pkg;

  typedef enum logic [1:0] {
    OP_LOAD      = 2'd0,
    OP_STORE     = 2'd1,
    OP_TAG_LOAD  = 2'd2,
    OP_TAG_STORE = 2'd3
  } mesh_op_e;

  // request from the master towards a cache tile.
  typedef struct packed {
    mesh_op_e                op;
    logic [`MC_ADDR_W-1:0]   addr;
    logic [`MC_DATA_W-1:0]   data;
    logic [`MC_X_W-1:0]      src_x;
    logic [`MC_Y_W-1:0]      src_y;
    logic [`MC_X_W-1:0]      dst_x;
    logic [`MC_Y_W-1:0]      dst_y;
  } mesh_req_s;

  // response, op echoes the request.
  typedef struct packed {
    mesh_op_e                op;
    logic [`MC_DATA_W-1:0]   data;
  } mesh_rsp_s;

endpackage

// ==== hdl/cache_pkg.sv ====
/*
  Cache address split and tag storage types.
  One data word per line, so there is no offset field.
*/
`include "mesh_cache_config.svh"

package cache_pkg;

  localparam int CACHE_IDX_W = $clog2(`MC_SETS);
  localparam int CACHE_WAY_W = $clog2(`MC_WAYS);
  localparam int CACHE_TAG_W = `MC_ADDR_W - CACHE_IDX_W;

  typedef struct packed {
    logic [CACHE_TAG_W-1:0] tag;
    logic [CACHE_IDX_W-1:0] index;
  } cache_addr_s;

  typedef struct packed {
    logic                   valid;
    logic                   dirty;
    logic [CACHE_TAG_W-1:0] tag;
  } tag_entry_s;

  // entry number of a tag access, index major and way minor.
  typedef struct packed {
    logic [CACHE_IDX_W-1:0] index;
    logic [CACHE_WAY_W-1:0] way;
  } tag_ptr_s;

  typedef enum logic [2:0] {
    C_IDLE, C_LOOKUP, C_EVICT, C_FILL, C_RESPOND
  } cache_state_e;

endpackage

// ==== hdl/mesh_master_cache.sv ====
/*
  Traffic master: tag stores, tag loads, data stores, data loads, one burst each.
  start_i is taken only while no run is in flight.
  Store data is the address plus the pattern latched at start.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module mesh_master_cache (
  input  logic                     clock_i
  ,input  logic                    reset_i
  ,input  logic                    start_i
  ,input  logic [`MC_DATA_W-1:0]   pattern_i
  ,input  logic [`MC_X_W-1:0]      my_x_i
  ,input  logic [`MC_Y_W-1:0]      my_y_i
  ,output logic                    req_v_o
  ,output mesh_pkt_pkg::mesh_req_s req_o
  ,input  logic                    req_ready_i
  ,input  logic                    rsp_v_i
  ,input  mesh_pkt_pkg::mesh_rsp_s rsp_i
  ,output logic                    finish_o
  ,output logic                    busy_o
);
  import mesh_pkt_pkg::*;

  localparam int TAG_N = `MC_SETS * `MC_WAYS;
  localparam int CNT_W = $clog2(2 * `MC_MEM_SIZE);
  localparam int TOT_W = $clog2(2 * TAG_N + 2 * `MC_MEM_SIZE + 1);
  localparam logic [`MC_X_W-1:0] CACHE_X = `MC_X_W'(1);
  localparam logic [`MC_Y_W-1:0] CACHE_Y = `MC_Y_W'(1);

  typedef enum logic [2:0] {
    S_IDLE, S_TAG_STORE, S_TAG_LOAD, S_DATA_STORE, S_DATA_LOAD, S_DONE
  } send_state_e;

  typedef enum logic [1:0] {
    R_IDLE, R_TAG, R_DATA, R_DONE
  } recv_state_e;

  send_state_e           send_r;
  recv_state_e           recv_r;
  logic [CNT_W-1:0]      send_cnt_r;
  logic [CNT_W-1:0]      recv_cnt_r;
  logic [TOT_W-1:0]      sent_tot_r;
  logic [TOT_W-1:0]      recv_tot_r;
  logic [`MC_DATA_W-1:0] pattern_r;
  logic                  start_ok;
  logic                  req_fire;
  logic                  send_last;
  logic                  recv_last;

  assign busy_o    = (recv_r == R_TAG) || (recv_r == R_DATA);
  assign finish_o  = (send_r == S_DONE) && (recv_r == R_DONE);
  assign start_ok  = start_i && !busy_o;
  assign req_v_o   = (send_r != S_IDLE) && (send_r != S_DONE);
  assign req_fire  = req_v_o && req_ready_i;
  assign send_last = (send_r == S_TAG_STORE || send_r == S_TAG_LOAD) ?
                     (send_cnt_r == CNT_W'(TAG_N - 1)) :
                     (send_cnt_r == CNT_W'(`MC_MEM_SIZE - 1));
  assign recv_last = (recv_r == R_TAG) ? (recv_cnt_r == CNT_W'(2 * TAG_N - 1)) :
                                         (recv_cnt_r == CNT_W'(2 * `MC_MEM_SIZE - 1));

  always_comb begin
    req_o       = '0;
    req_o.src_x = my_x_i;
    req_o.src_y = my_y_i;
    req_o.dst_x = CACHE_X;
    req_o.dst_y = CACHE_Y;
    req_o.addr  = `MC_ADDR_W'(send_cnt_r);
    case (send_r)
      S_TAG_STORE: begin
        req_o.op   = OP_TAG_STORE;
        req_o.addr = `MC_ADDR_W'(send_cnt_r) << 3;  // entry number times 8.
        req_o.data = `MC_DATA_W'(send_cnt_r);
      end
      S_TAG_LOAD: begin
        req_o.op   = OP_TAG_LOAD;
        req_o.addr = `MC_ADDR_W'(send_cnt_r) << 3;
      end
      S_DATA_STORE: begin
        req_o.op   = OP_STORE;
        req_o.data = `MC_DATA_W'(send_cnt_r) + pattern_r;
      end
      default: req_o.op = OP_LOAD;
    endcase
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      send_r     <= S_IDLE;
      recv_r     <= R_IDLE;
      send_cnt_r <= '0;
      recv_cnt_r <= '0;
      sent_tot_r <= '0;
      recv_tot_r <= '0;
    end else if (start_ok) begin
      send_r     <= S_TAG_STORE;
      recv_r     <= R_TAG;
      send_cnt_r <= '0;
      recv_cnt_r <= '0;
      sent_tot_r <= '0;
      recv_tot_r <= '0;
      pattern_r  <= pattern_i;
    end else begin
      if (req_fire) begin
        sent_tot_r <= sent_tot_r + 1'b1;
        send_cnt_r <= send_last ? '0 : send_cnt_r + 1'b1;
        if (send_last) begin
          send_r <= send_state_e'(send_r + 3'd1);  // bursts are encoded in order.
        end
      end
      if (rsp_v_i) begin
        recv_tot_r <= recv_tot_r + 1'b1;
        recv_cnt_r <= recv_last ? '0 : recv_cnt_r + 1'b1;
        if (recv_last) begin
          recv_r <= (recv_r == R_TAG) ? R_DATA : R_DONE;
        end
      end
    end
  end

  // a response can only follow a request that went out earlier.
  a_recv_le_sent: assert property (@(posedge clock_i) disable iff (reset_i)
    recv_tot_r <= sent_tot_r);

  // in-order return: tag responses all come before any data response.
  a_tag_rsp_order: assert property (@(posedge clock_i) disable iff (reset_i)
    rsp_v_i && (recv_r == R_TAG) |-> rsp_i.op inside {OP_TAG_LOAD, OP_TAG_STORE});

endmodule

// ==== hdl/mesh_endpoint.sv ====
/*
  Network endpoint: request FIFO, credit counter and a one-entry response register.
  A credit returns when the response is taken at rsp_o.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module mesh_endpoint (
  input  logic                     clock_i
  ,input  logic                    reset_i
  ,input  logic                    req_v_i
  ,input  mesh_pkt_pkg::mesh_req_s req_i
  ,output logic                    req_ready_o
  ,output logic                    net_req_v_o
  ,output mesh_pkt_pkg::mesh_req_s net_req_o
  ,input  logic                    net_req_ready_i
  ,input  logic                    net_rsp_v_i
  ,input  mesh_pkt_pkg::mesh_rsp_s net_rsp_i
  ,output logic                    net_rsp_ready_o
  ,output logic                    rsp_v_o
  ,output mesh_pkt_pkg::mesh_rsp_s rsp_o
  ,input  logic                    rsp_ready_i
);
  import mesh_pkt_pkg::*;

  localparam int PTR_W  = $clog2(`MC_FIFO_ELS);
  localparam int CNT_W  = $clog2(`MC_FIFO_ELS + 1);
  localparam int CRED_W = $clog2(`MC_MAX_CREDITS + 1);

  mesh_req_s         fifo_q [`MC_FIFO_ELS];
  logic [PTR_W-1:0]  wr_ptr_r;
  logic [PTR_W-1:0]  rd_ptr_r;
  logic [CNT_W-1:0]  fifo_cnt_r;
  logic [CRED_W-1:0] credits_r;  // requests outstanding.
  mesh_rsp_s         rsp_r;
  logic              rsp_v_r;
  logic              req_fire;
  logic              deq_fire;
  logic              rsp_fire;

  assign req_ready_o = (fifo_cnt_r != CNT_W'(`MC_FIFO_ELS)) &&
                       (credits_r != CRED_W'(`MC_MAX_CREDITS));
  assign req_fire    = req_v_i && req_ready_o;
  assign net_req_v_o = (fifo_cnt_r != '0);
  assign net_req_o   = fifo_q[rd_ptr_r];
  assign deq_fire    = net_req_v_o && net_req_ready_i;

  assign net_rsp_ready_o = !rsp_v_r || rsp_ready_i;
  assign rsp_v_o         = rsp_v_r;
  assign rsp_o           = rsp_r;
  assign rsp_fire        = rsp_v_r && rsp_ready_i;

  always_ff @(posedge clock_i) begin
    if (req_fire) begin
      fifo_q[wr_ptr_r] <= req_i;
    end
    if (net_rsp_v_i && net_rsp_ready_o) begin
      rsp_r <= net_rsp_i;
    end
  end

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      fifo_cnt_r <= '0;
      credits_r  <= '0;
      rsp_v_r    <= 1'b0;
    end else begin
      wr_ptr_r   <= wr_ptr_r + PTR_W'(req_fire);
      rd_ptr_r   <= rd_ptr_r + PTR_W'(deq_fire);
      fifo_cnt_r <= fifo_cnt_r + CNT_W'(req_fire) - CNT_W'(deq_fire);
      credits_r  <= credits_r + CRED_W'(req_fire) - CRED_W'(rsp_fire);
      if (net_rsp_ready_o) begin
        rsp_v_r <= net_rsp_v_i;
      end
    end
  end

  a_credit_underflow: assert property (@(posedge clock_i) disable iff (reset_i)
    rsp_fire |-> credits_r != '0);

  // queued requests are a subset of the outstanding ones.
  a_fifo_bound: assert property (@(posedge clock_i) disable iff (reset_i)
    (fifo_cnt_r <= CNT_W'(`MC_FIFO_ELS)) && (fifo_cnt_r <= credits_r));

endmodule

// ==== hdl/cache_tile.sv ====
/*
  Blocking, write-back, write-allocate cache tile, one word per line.
  Round-robin victim per set. Tag ops address entry addr/8, index major.
  A tag store overwrites the entry and drops any dirty data in it.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module cache_tile (
  input  logic                     clock_i
  ,input  logic                    reset_i
  ,input  logic                    req_v_i
  ,input  mesh_pkt_pkg::mesh_req_s req_i
  ,output logic                    req_ready_o
  ,output logic                    rsp_v_o
  ,output mesh_pkt_pkg::mesh_rsp_s rsp_o
  ,input  logic                    rsp_ready_i
  ,output logic                    mem_v_o
  ,output logic                    mem_we_o
  ,output logic [`MC_ADDR_W-1:0]   mem_addr_o
  ,output logic [`MC_DATA_W-1:0]   mem_wdata_o
  ,input  logic                    mem_ready_i
  ,input  logic                    mem_rvalid_i
  ,input  logic [`MC_DATA_W-1:0]   mem_rdata_i
);
  import mesh_pkt_pkg::*;
  import cache_pkg::*;

  cache_state_e          state_r;
  mesh_req_s             req_r;
  mesh_rsp_s             rsp_r;
  logic                  rsp_v_r;
  logic                  fill_sent_r;  // fill read accepted, waiting for data.
  tag_entry_s            tags_r [`MC_SETS][`MC_WAYS];
  logic [`MC_DATA_W-1:0] data_r [`MC_SETS][`MC_WAYS];
  logic [CACHE_WAY_W-1:0] rr_r [`MC_SETS];

  cache_addr_s           addr;
  tag_ptr_s              ptr;
  logic                  hit;
  logic [CACHE_WAY_W-1:0] hit_way;
  logic [CACHE_WAY_W-1:0] victim;
  tag_entry_s            victim_tag;

  assign addr       = req_r.addr;
  assign ptr        = req_r.addr[3 +: $bits(tag_ptr_s)];
  assign victim     = rr_r[addr.index];
  assign victim_tag = tags_r[addr.index][victim];

  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = 0; w < `MC_WAYS; w++) begin
      if (tags_r[addr.index][w].valid && (tags_r[addr.index][w].tag == addr.tag)) begin
        hit     = 1'b1;
        hit_way = CACHE_WAY_W'(w);
      end
    end
  end

  assign req_ready_o = (state_r == C_IDLE);
  assign rsp_v_o     = rsp_v_r;
  assign rsp_o       = rsp_r;
  assign mem_v_o     = (state_r == C_EVICT) || ((state_r == C_FILL) && !fill_sent_r);
  assign mem_we_o    = (state_r == C_EVICT);
  assign mem_addr_o  = mem_we_o ? {victim_tag.tag, addr.index} : req_r.addr;
  assign mem_wdata_o = data_r[addr.index][victim];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_r     <= C_IDLE;
      rsp_v_r     <= 1'b0;
      fill_sent_r <= 1'b0;
      for (int s = 0; s < `MC_SETS; s++) begin
        rr_r[s] <= '0;
        for (int w = 0; w < `MC_WAYS; w++) begin
          tags_r[s][w] <= '0;
        end
      end
    end else begin
      case (state_r)
        C_IDLE: begin
          if (req_v_i) begin
            req_r   <= req_i;
            state_r <= C_LOOKUP;
          end
        end
        C_LOOKUP: begin
          state_r    <= C_RESPOND;
          rsp_v_r    <= 1'b1;
          rsp_r.op   <= req_r.op;
          rsp_r.data <= '0;
          if (req_r.op == OP_TAG_STORE) begin
            tags_r[ptr.index][ptr.way] <= '{valid: 1'b0, dirty: 1'b0,
                                            tag: req_r.data[CACHE_TAG_W-1:0]};
          end else if (req_r.op == OP_TAG_LOAD) begin
            rsp_r.data <= `MC_DATA_W'(tags_r[ptr.index][ptr.way]);
          end else if (!hit) begin
            rsp_v_r <= 1'b0;
            state_r <= (victim_tag.valid && victim_tag.dirty) ? C_EVICT : C_FILL;
          end else if (req_r.op == OP_STORE) begin
            data_r[addr.index][hit_way]       <= req_r.data;
            tags_r[addr.index][hit_way].dirty <= 1'b1;
          end else begin
            rsp_r.data <= data_r[addr.index][hit_way];
          end
        end
        C_EVICT: begin
          if (mem_ready_i) begin
            state_r <= C_FILL;
          end
        end
        C_FILL: begin
          if (mem_v_o && mem_ready_i) begin
            fill_sent_r <= 1'b1;
          end
          if (mem_rvalid_i) begin
            fill_sent_r               <= 1'b0;
            data_r[addr.index][victim] <= mem_rdata_i;
            tags_r[addr.index][victim] <= '{valid: 1'b1, dirty: 1'b0, tag: addr.tag};
            rr_r[addr.index]          <= victim + 1'b1;
            state_r                   <= C_LOOKUP;  // now a hit.
          end
        end
        C_RESPOND: begin
          if (rsp_ready_i) begin
            rsp_v_r <= 1'b0;
            state_r <= C_IDLE;
          end
        end
        default: state_r <= C_IDLE;
      endcase
    end
  end

  a_no_rsp_in_idle: assert property (@(posedge clock_i) disable iff (reset_i)
    (state_r == C_IDLE) |-> !rsp_v_r);

endmodule

// ==== hdl/backing_mem.sv ====
/*
  Word memory behind the cache, one access at a time.
  Reads return MC_MEM_LAT cycles after acceptance, writes take one cycle.
  Contents start undefined and only the low address bits are decoded.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module backing_mem (
  input  logic                   clock_i
  ,input  logic                  reset_i
  ,input  logic                  mem_v_i
  ,input  logic                  mem_we_i
  ,input  logic [`MC_ADDR_W-1:0] mem_addr_i
  ,input  logic [`MC_DATA_W-1:0] mem_wdata_i
  ,output logic                  mem_ready_o
  ,output logic                  mem_rvalid_o
  ,output logic [`MC_DATA_W-1:0] mem_rdata_o
);
  localparam int WA_W = $clog2(`MC_MEM_SIZE);

  logic [`MC_DATA_W-1:0] mem_q [`MC_MEM_SIZE];
  logic [`MC_MEM_LAT-1:0] lat_r;  // one bit per cycle of a read in flight.
  logic [WA_W-1:0]        raddr_r;
  logic                   rd_fire;

  assign mem_ready_o  = ~|lat_r;
  assign rd_fire      = mem_v_i && mem_ready_o && !mem_we_i;
  assign mem_rvalid_o = lat_r[`MC_MEM_LAT-1];
  assign mem_rdata_o  = mem_q[raddr_r];

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      lat_r <= '0;
    end else begin
      lat_r <= (lat_r << 1) | `MC_MEM_LAT'(rd_fire);
    end
  end

  always_ff @(posedge clock_i) begin
    if (mem_v_i && mem_ready_o) begin
      if (mem_we_i) begin
        mem_q[mem_addr_i[WA_W-1:0]] <= mem_wdata_i;
      end else begin
        raddr_r <= mem_addr_i[WA_W-1:0];
      end
    end
  end

endmodule

// ==== hdl/mesh_cache_top.sv ====
/*
  Master, endpoint, cache tile and backing memory on one link, no routers.
  rsp_o is the response tap; the master sees a response once it is taken.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module mesh_cache_top (
  input  logic                     clock_i
  ,input  logic                    reset_i
  ,input  logic                    start_i
  ,input  logic [`MC_DATA_W-1:0]   pattern_i
  ,input  logic [`MC_X_W-1:0]      my_x_i
  ,input  logic [`MC_Y_W-1:0]      my_y_i
  ,input  logic                    rsp_ready_i
  ,output logic                    rsp_v_o
  ,output mesh_pkt_pkg::mesh_rsp_s rsp_o
  ,output logic                    finish_o
  ,output logic                    busy_o
);
  import mesh_pkt_pkg::*;

  mesh_req_s             req;
  mesh_req_s             net_req;
  mesh_rsp_s             net_rsp;
  logic                  req_v, req_ready;
  logic                  net_req_v, net_req_ready;
  logic                  net_rsp_v, net_rsp_ready;
  logic                  rsp_done;
  logic                  mem_v, mem_we, mem_ready, mem_rvalid;
  logic [`MC_ADDR_W-1:0] mem_addr;
  logic [`MC_DATA_W-1:0] mem_wdata, mem_rdata;

  assign rsp_done = rsp_v_o && rsp_ready_i;  // transfer completed at the tap.

  mesh_master_cache i_master (
    .clock_i, .reset_i, .start_i, .pattern_i, .my_x_i, .my_y_i,
    .req_v_o(req_v), .req_o(req), .req_ready_i(req_ready),
    .rsp_v_i(rsp_done), .rsp_i(rsp_o), .finish_o, .busy_o
  );

  mesh_endpoint i_endpoint (
    .clock_i, .reset_i,
    .req_v_i(req_v), .req_i(req), .req_ready_o(req_ready),
    .net_req_v_o(net_req_v), .net_req_o(net_req), .net_req_ready_i(net_req_ready),
    .net_rsp_v_i(net_rsp_v), .net_rsp_i(net_rsp), .net_rsp_ready_o(net_rsp_ready),
    .rsp_v_o, .rsp_o, .rsp_ready_i
  );

  cache_tile i_cache (
    .clock_i, .reset_i,
    .req_v_i(net_req_v), .req_i(net_req), .req_ready_o(net_req_ready),
    .rsp_v_o(net_rsp_v), .rsp_o(net_rsp), .rsp_ready_i(net_rsp_ready),
    .mem_v_o(mem_v), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_ready_i(mem_ready), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
  );

  backing_mem i_mem (
    .clock_i, .reset_i,
    .mem_v_i(mem_v), .mem_we_i(mem_we), .mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
    .mem_ready_o(mem_ready), .mem_rvalid_o(mem_rvalid), .mem_rdata_o(mem_rdata)
  );

endmodule

// ==== test/tb_mesh_cache.sv ====
/*
  Directed testbench for the mesh cache subsystem, two runs of the four bursts.
  Expected responses come from the payload rules, in request order.
  The second run stalls rsp_ready_i in LFSR-chosen cycles.
*/
`timescale 1ns/1ns
`include "mesh_cache_config.svh"

module tb_mesh_cache;
  import mesh_pkt_pkg::*;

  localparam int TAG_N       = `MC_SETS * `MC_WAYS;
  localparam int TAG_RSP     = 2 * TAG_N;                   // tag stores, then tag loads.
  localparam int RUN_RSP     = TAG_RSP + 2 * `MC_MEM_SIZE;
  localparam int WORST_LAT   = 20;                          // dirty miss under stalls.
  localparam int CYCLE_LIMIT = 5 * RUN_RSP * WORST_LAT + 800;  // two runs with margin.

  logic                  clock_i;
  logic                  reset_i;
  logic                  start_i;
  logic [`MC_DATA_W-1:0] pattern_i;
  logic [`MC_X_W-1:0]    my_x_i;
  logic [`MC_Y_W-1:0]    my_y_i;
  logic                  rsp_ready_i;
  logic                  rsp_v_o;
  mesh_rsp_s             rsp_o;
  logic                  finish_o;
  logic                  busy_o;

  mesh_rsp_s   exp_q [$];
  mesh_rsp_s   exp_rsp;
  mesh_rsp_s   held_rsp;
  logic        held_v = 1'b0;
  logic        stall_en = 1'b0;
  int          rx_cnt = 0;
  int          stall_cnt = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_r = 32'h9e85;

  mesh_cache_top i_mesh_cache_top (
    .clock_i, .reset_i, .start_i, .pattern_i, .my_x_i, .my_y_i,
    .rsp_ready_i, .rsp_v_o, .rsp_o, .finish_o, .busy_o
  );

  always #20 clock_i = ~clock_i;

  task automatic stop_with_failure(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken.
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_r = {lfsr_r[30:0], lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0]};
      bits   = {bits[30:0], lfsr_r[0]};
    end
    return bits;
  endfunction

  task automatic wait_cycle();
    @(posedge clock_i);
    #2;
  endtask

  // outputs settle after the rising edge, the monitor runs at the falling one.
  task automatic wait_sample();
    @(negedge clock_i);
    #1;
  endtask

  task automatic push_expected(input mesh_op_e op, input logic [`MC_DATA_W-1:0] data);
    mesh_rsp_s rsp;
    rsp.op   = op;
    rsp.data = data;
    exp_q.push_back(rsp);
  endtask

  task automatic build_expected(input logic [`MC_DATA_W-1:0] pattern);
    for (int e = 0; e < TAG_N; e++) begin
      push_expected(OP_TAG_STORE, '0);
    end
    // entry e holds tag e with valid and dirty clear.
    for (int e = 0; e < TAG_N; e++) begin
      push_expected(OP_TAG_LOAD, `MC_DATA_W'(e));
    end
    for (int a = 0; a < `MC_MEM_SIZE; a++) begin
      push_expected(OP_STORE, '0);
    end
    for (int a = 0; a < `MC_MEM_SIZE; a++) begin
      push_expected(OP_LOAD, `MC_DATA_W'(a) + pattern);
    end
  endtask

  always @(posedge clock_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      stop_with_failure($sformatf("Timeout: the run did not end within %0d cycles",
                                  CYCLE_LIMIT));
    end
  end

  always @(posedge clock_i) begin
    #2;
    if (stall_en) begin
      rsp_ready_i = (lfsr_bits(2) != 2'b11);  // stalls about one cycle in four.
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  // response monitor.
  always @(negedge clock_i) begin
    if (!reset_i) begin
      if (held_v) begin
        assert (rsp_v_o && (rsp_o == held_rsp))
          else stop_with_failure("A stalled response changed or was dropped");
      end
      if (finish_o) begin
        assert (exp_q.size() == 0)
          else stop_with_failure("finish_o rose while responses were still due");
      end
      if (rsp_v_o && rsp_ready_i) begin
        assert (exp_q.size() != 0)
          else stop_with_failure("A response arrived when none was expected");
        exp_rsp = exp_q.pop_front();
        assert (rsp_o == exp_rsp)
          else stop_with_failure($sformatf(
            "FAILED at %0t ns: response %0d got op %0d data %h, expected op %0d data %h",
            $time, rx_cnt, rsp_o.op, rsp_o.data, exp_rsp.op, exp_rsp.data));
        rx_cnt++;
      end
      held_v   = rsp_v_o && !rsp_ready_i;
      held_rsp = rsp_o;
      if (held_v) begin
        stall_cnt++;
      end
    end
  end

  task automatic test_reset_state();
    repeat (6) begin
      wait_sample();
      assert (!rsp_v_o && !finish_o && !busy_o)
        else stop_with_failure("Outputs were not low after reset");
    end
  endtask

  task automatic check_tag_phase();
    while (rx_cnt < TAG_RSP) begin
      wait_sample();
      assert (busy_o && !finish_o)
        else stop_with_failure("busy_o or finish_o was wrong during the tag phase");
    end
  endtask

  task automatic check_data_phase();
    while (rx_cnt < RUN_RSP) begin
      wait_sample();
      assert (busy_o)
        else stop_with_failure("busy_o dropped before the last data response");
    end
  endtask

  task automatic check_completion();
    while (!finish_o) begin
      wait_sample();
    end
    repeat (8) begin
      wait_sample();
      assert (finish_o && !busy_o && !rsp_v_o)
        else stop_with_failure("finish_o did not stay high after the run");
    end
    assert (exp_q.size() == 0)
      else stop_with_failure("Some expected responses never arrived");
  endtask

  task automatic run_burst_sequence(input logic stall);
    logic [`MC_DATA_W-1:0] pattern;
    @(negedge clock_i);
    pattern   = lfsr_bits(32);
    stall_en  = stall;
    stall_cnt = 0;
    rx_cnt    = 0;
    wait_cycle();
    pattern_i = pattern;
    start_i   = 1'b1;
    wait_cycle();
    start_i   = 1'b0;
    build_expected(pattern);
    check_tag_phase();
    check_data_phase();
    check_completion();
    if (stall) begin
      assert (stall_cnt > 0)
        else stop_with_failure("No response was ever stalled in the back-pressure run");
    end
    stall_en = 1'b0;
  endtask

  initial begin
    clock_i     = 1'b0;
    reset_i     = 1'b1;
    start_i     = 1'b0;
    pattern_i   = '0;
    my_x_i      = `MC_X_W'(2);
    my_y_i      = `MC_Y_W'(3);
    rsp_ready_i = 1'b1;
    repeat (4) @(posedge clock_i);
    #2;
    reset_i = 1'b0;
    test_reset_state();
    run_burst_sequence(1'b0);  // first run, no stalls.
    run_burst_sequence(1'b1);  // second run, new pattern under back-pressure.
    $display("Test OK");
    $finish;
  end

endmodule

// ==== mesh_cache.f ====
+incdir+hdl
hdl/mesh_pkt_pkg.sv
hdl/cache_pkg.sv
hdl/mesh_master_cache.sv
hdl/mesh_endpoint.sv
hdl/cache_tile.sv
hdl/backing_mem.sv
hdl/mesh_cache_top.sv
test/tb_mesh_cache.sv

// ==== Bender.yml ====
package:
  name: mesh_cache

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/mesh_pkt_pkg.sv
      - hdl/cache_pkg.sv
      - hdl/mesh_master_cache.sv
      - hdl/mesh_endpoint.sv
      - hdl/cache_tile.sv
      - hdl/backing_mem.sv
      - hdl/mesh_cache_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mesh_cache.sv
